/* source/backprop_pkg.sv */
package backprop_pkg;

    // Q8.8 element format
    localparam int DATA_W = 16;
    localparam int FRAC_W = 8;

    // lanes per vector, also the samples per batch
    localparam int LANES = 3;
    localparam int MAX_LAYERS = 4;

    localparam int LAYER_W = 2;
    localparam int ROW_W = 2;

    // one update address per layer and row pair
    localparam int ENTRIES = MAX_LAYERS * LANES;

    // decoder, store, mac and scaler register stages
    localparam int MAC_LATENCY = 4;

    typedef logic signed [DATA_W-1:0] data_t;

    // lane 0 sits in the most significant slice
    typedef data_t [0:LANES-1] vec_t;

    // one vector per batch sample, sample 0 on top
    typedef vec_t [0:LANES-1] batch_t;

    typedef logic [LAYER_W-1:0] layer_t;
    typedef logic [ROW_W-1:0] row_t;

    // full signed product, rescaled back to Q8.8 with wrap
    function automatic data_t fx_mult(input data_t a, input data_t b);
        logic signed [31:0] prod;
        prod = 32'(a) * 32'(b);
        return data_t'(prod >>> FRAC_W);
    endfunction

    // plain wrapping add
    function automatic data_t fx_add(input data_t a, input data_t b);
        data_t sum;
        sum = a + b;
        return sum;
    endfunction

endpackage

/* source/backprop_decoder.sv */
`timescale 1ns/1ps

module backprop_decoder (
    input  logic                 clk,
    input  logic                 arst_n_i,

    // store command from the training phase
    input  logic                 store_i,
    input  backprop_pkg::layer_t layer_i,
    input  backprop_pkg::row_t   row_i,
    input  backprop_pkg::vec_t   diff_cost_i,
    input  backprop_pkg::vec_t   diff_act_i,

    // update phase level
    input  logic                 read_update_i,

    // store write port
    output logic                 wr_en_o,
    output backprop_pkg::layer_t wr_layer_o,
    output backprop_pkg::row_t   wr_slot_o,
    output backprop_pkg::vec_t   delta_o,

    // update read address
    output logic                 rd_valid_o,
    output backprop_pkg::layer_t rd_layer_o,
    output backprop_pkg::row_t   rd_row_o
);

    // walks 0 .. ENTRIES-1, layer major
    logic [$clog2(backprop_pkg::ENTRIES)-1:0] count_q;

    // samples past the batch size are dropped
    assign wr_en_o    = store_i && (int'(row_i) < backprop_pkg::LANES);
    assign wr_layer_o = layer_i;
    assign wr_slot_o  = row_i;

    // delta = cost gradient times activation derivative, per lane
    always_comb begin
        for (int j = 0; j < backprop_pkg::LANES; j++) begin
            delta_o[j] = backprop_pkg::fx_mult(diff_cost_i[j], diff_act_i[j]);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q    <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= read_update_i;
            if (!read_update_i) begin
                // restart from layer 0 row 0 on the next rise
                count_q <= '0;
            end else if (int'(count_q) == backprop_pkg::ENTRIES - 1) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // address tags, only meaningful with rd_valid_o
    always_ff @(posedge clk) begin
        rd_layer_o <= backprop_pkg::layer_t'(int'(count_q) / backprop_pkg::LANES);
        rd_row_o   <= backprop_pkg::row_t'(int'(count_q) % backprop_pkg::LANES);
    end

    // training and update phases are kept apart by the source
    assert property (@(posedge clk) disable iff (!arst_n_i)
        !(store_i && read_update_i))
        else $error("store_i and read_update_i high together");

endmodule

/* source/gradient_store.sv */
`timescale 1ns/1ps

module gradient_store (
    input  logic                 clk,
    input  logic                 arst_n_i,

    input  logic                 wr_en_i,
    input  backprop_pkg::layer_t wr_layer_i,
    input  backprop_pkg::row_t   wr_slot_i,
    input  backprop_pkg::vec_t   wr_data_i,

    input  logic                 rd_valid_i,
    input  backprop_pkg::layer_t rd_layer_i,
    input  backprop_pkg::row_t   rd_row_i,

    output backprop_pkg::batch_t batch_o,
    output logic                 valid_o,
    output backprop_pkg::row_t   row_o,
    output backprop_pkg::layer_t layer_o
);

    // one batch per layer
    backprop_pkg::batch_t mem_q [backprop_pkg::MAX_LAYERS];

    // cleared so an unwritten layer contributes nothing
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int l = 0; l < backprop_pkg::MAX_LAYERS; l++) begin
                mem_q[l] <= '0;
            end
            valid_o <= 1'b0;
        end else begin
            if (wr_en_i) begin
                mem_q[wr_layer_i][wr_slot_i] <= wr_data_i;
            end
            valid_o <= rd_valid_i;
        end
    end

    // whole layer read, tag follows alongside
    always_ff @(posedge clk) begin
        batch_o <= mem_q[rd_layer_i];
        row_o   <= rd_row_i;
        layer_o <= rd_layer_i;
    end

    // the decoder must have filtered out-of-range samples
    assert property (@(posedge clk) disable iff (!arst_n_i)
        wr_en_i |-> (int'(wr_slot_i) < backprop_pkg::LANES))
        else $error("write slot out of range");

endmodule

/* source/outer_product_mac.sv */
`timescale 1ns/1ps

module outer_product_mac (
    input  logic                 clk,
    input  logic                 arst_n_i,

    // address tag of the batches below
    input  logic                 valid_i,
    input  backprop_pkg::layer_t layer_i,
    input  backprop_pkg::row_t   row_i,

    // delta and start vectors of every sample in the layer
    input  backprop_pkg::batch_t delta_batch_i,
    input  backprop_pkg::batch_t start_batch_i,

    output logic                 valid_o,
    output backprop_pkg::layer_t layer_o,
    output backprop_pkg::row_t   row_o,
    output backprop_pkg::vec_t   sum_o
);

    backprop_pkg::vec_t   sum_d;

    // delta[k][row] for each sample k
    backprop_pkg::data_t  delta_sel [backprop_pkg::LANES];

    always_comb begin
        for (int k = 0; k < backprop_pkg::LANES; k++) begin
            delta_sel[k] = delta_batch_i[k][row_i];
        end
    end

    // one row of sum over k of delta[k] outer start[k]
    always_comb begin
        backprop_pkg::data_t acc;
        for (int j = 0; j < backprop_pkg::LANES; j++) begin
            acc = '0;
            for (int k = 0; k < backprop_pkg::LANES; k++) begin
                acc = backprop_pkg::fx_add(acc,
                    backprop_pkg::fx_mult(delta_sel[k], start_batch_i[k][j]));
            end
            sum_d[j] = acc;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        layer_o <= layer_i;
        row_o   <= row_i;
        sum_o   <= sum_d;
    end

endmodule

/* source/rate_scaler.sv */
`timescale 1ns/1ps

module rate_scaler (
    input  logic                 clk,
    input  logic                 arst_n_i,

    input  logic                 valid_i,
    input  backprop_pkg::layer_t layer_i,
    input  backprop_pkg::row_t   row_i,
    input  backprop_pkg::vec_t   sum_i,

    // sampled every cycle, no hold needed
    input  backprop_pkg::data_t  learning_rate_i,

    output logic                 update_valid_o,
    output backprop_pkg::layer_t update_layer_o,
    output backprop_pkg::row_t   update_row_o,
    output backprop_pkg::vec_t   update_value_o
);

    backprop_pkg::vec_t scaled;

    // lane-wise rate times summed gradient
    always_comb begin
        for (int j = 0; j < backprop_pkg::LANES; j++) begin
            scaled[j] = backprop_pkg::fx_mult(learning_rate_i, sum_i[j]);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            update_valid_o <= 1'b0;
        end else begin
            update_valid_o <= valid_i;
        end
    end

    // output payload
    always_ff @(posedge clk) begin
        update_layer_o <= layer_i;
        update_row_o   <= row_i;
        update_value_o <= scaled;
    end

    // the whole valid chain must come out of reset clean
    assert property (@(posedge clk) disable iff (!arst_n_i)
        !$isunknown(update_valid_o))
        else $error("update_valid_o unknown");

endmodule

/* source/backprop_update.sv */
`timescale 1ns/1ps

module backprop_update (
    input  logic                 clk,
    input  logic                 arst_n_i,

    // training phase, one strobe per sample
    input  logic                 store_i,
    input  backprop_pkg::layer_t layer_i,
    input  backprop_pkg::row_t   row_i,
    input  backprop_pkg::vec_t   diff_cost_i,
    input  backprop_pkg::vec_t   diff_act_i,
    input  backprop_pkg::vec_t   diff_start_i,

    // update phase
    input  logic                 read_update_i,
    input  backprop_pkg::data_t  learning_rate_i,

    output logic                 update_valid_o,
    output backprop_pkg::layer_t update_layer_o,
    output backprop_pkg::row_t   update_row_o,
    output backprop_pkg::vec_t   update_value_o
);

    logic                 wr_en;
    backprop_pkg::layer_t wr_layer;
    backprop_pkg::row_t   wr_slot;
    backprop_pkg::vec_t   delta;

    logic                 rd_valid;
    backprop_pkg::layer_t rd_layer;
    backprop_pkg::row_t   rd_row;

    backprop_pkg::batch_t delta_batch;
    logic                 delta_valid;
    backprop_pkg::row_t   delta_row;
    backprop_pkg::layer_t delta_layer;

    backprop_pkg::batch_t start_batch;

    logic                 mac_valid;
    backprop_pkg::layer_t mac_layer;
    backprop_pkg::row_t   mac_row;
    backprop_pkg::vec_t   mac_sum;

    backprop_decoder u_decoder (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .store_i       (store_i),
        .layer_i       (layer_i),
        .row_i         (row_i),
        .diff_cost_i   (diff_cost_i),
        .diff_act_i    (diff_act_i),
        .read_update_i (read_update_i),
        .wr_en_o       (wr_en),
        .wr_layer_o    (wr_layer),
        .wr_slot_o     (wr_slot),
        .delta_o       (delta),
        .rd_valid_o    (rd_valid),
        .rd_layer_o    (rd_layer),
        .rd_row_o      (rd_row)
    );

    gradient_store u_delta_store (
        .clk (clk), .arst_n_i (arst_n_i),
        .wr_en_i (wr_en), .wr_layer_i (wr_layer), .wr_slot_i (wr_slot),
        .wr_data_i (delta),
        .rd_valid_i (rd_valid), .rd_layer_i (rd_layer), .rd_row_i (rd_row),
        .batch_o (delta_batch), .valid_o (delta_valid),
        .row_o (delta_row), .layer_o (delta_layer)
    );

    // same write slot, start vector taken straight from the input
    // tag comes from the delta store, which sees the same read address
    gradient_store u_start_store (
        .clk (clk), .arst_n_i (arst_n_i),
        .wr_en_i (wr_en), .wr_layer_i (wr_layer), .wr_slot_i (wr_slot),
        .wr_data_i (diff_start_i),
        .rd_valid_i (rd_valid), .rd_layer_i (rd_layer), .rd_row_i (rd_row),
        .batch_o (start_batch), .valid_o (),
        .row_o (), .layer_o ()
    );

    outer_product_mac u_mac (
        .clk (clk), .arst_n_i (arst_n_i),
        .valid_i (delta_valid), .layer_i (delta_layer), .row_i (delta_row),
        .delta_batch_i (delta_batch), .start_batch_i (start_batch),
        .valid_o (mac_valid), .layer_o (mac_layer), .row_o (mac_row),
        .sum_o (mac_sum)
    );

    rate_scaler u_scaler (
        .clk (clk), .arst_n_i (arst_n_i),
        .valid_i (mac_valid), .layer_i (mac_layer), .row_i (mac_row),
        .sum_i (mac_sum), .learning_rate_i (learning_rate_i),
        .update_valid_o (update_valid_o), .update_layer_o (update_layer_o),
        .update_row_o (update_row_o), .update_value_o (update_value_o)
    );

endmodule

/* testbench/tb_backprop_update.sv */
`timescale 1ns/1ps

module tb_backprop_update;

    localparam int LAT = backprop_pkg::MAC_LATENCY;
    localparam int NL = backprop_pkg::MAX_LAYERS;
    localparam int NV = backprop_pkg::LANES;

    logic                 clk;
    logic                 arst_n_i;
    logic                 store_i;
    backprop_pkg::layer_t layer_i;
    backprop_pkg::row_t   row_i;
    backprop_pkg::vec_t   diff_cost_i;
    backprop_pkg::vec_t   diff_act_i;
    backprop_pkg::vec_t   diff_start_i;
    logic                 read_update_i;
    backprop_pkg::data_t  learning_rate_i;
    logic                 update_valid_o;
    backprop_pkg::layer_t update_layer_o;
    backprop_pkg::row_t   update_row_o;
    backprop_pkg::vec_t   update_value_o;

    // shadow of both stores, [layer][sample][lane]
    logic signed [15:0] model_delta [NL][NV][NV];
    logic signed [15:0] model_start [NL][NV][NV];

    // expected pipeline, one stage per register stage of the dut
    logic                 exp_valid [LAT];
    backprop_pkg::layer_t exp_layer [LAT];
    backprop_pkg::row_t   exp_row   [LAT];
    backprop_pkg::vec_t   exp_value [LAT];
    int                   tb_count;

    logic [31:0] rng_state = 32'd93523;
    int          beats;
    int          expected_beats;

    backprop_update u_backprop_update (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .store_i         (store_i),
        .layer_i         (layer_i),
        .row_i           (row_i),
        .diff_cost_i     (diff_cost_i),
        .diff_act_i      (diff_act_i),
        .diff_start_i    (diff_start_i),
        .read_update_i   (read_update_i),
        .learning_rate_i (learning_rate_i),
        .update_valid_o  (update_valid_o),
        .update_layer_o  (update_layer_o),
        .update_row_o    (update_row_o),
        .update_value_o  (update_value_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // small signed Q8.8 values, roughly -4.0 .. 4.0
    function automatic logic signed [15:0] rand_elem();
        rng_state = xorshift32(rng_state);
        return {{5{rng_state[10]}}, rng_state[10:0]};
    endfunction

    // Q8.8 product: full signed multiply, drop 8 fraction bits, keep 16 bits
    function automatic logic signed [15:0] q88_product(input logic signed [15:0] a,
                                                      input logic signed [15:0] b);
        logic signed [31:0] wide;
        wide = a * b;
        return wide[backprop_pkg::FRAC_W +: backprop_pkg::DATA_W];
    endfunction

    function automatic backprop_pkg::vec_t expected_row(input int l, input int r,
                                                        input logic signed [15:0] lr);
        backprop_pkg::vec_t res;
        logic signed [15:0] acc;
        for (int j = 0; j < NV; j++) begin
            acc = '0;
            for (int k = 0; k < NV; k++) begin
                acc = acc + q88_product(model_delta[l][k][r], model_start[l][k][j]);
            end
            res[j] = q88_product(lr, acc);
        end
        return res;
    endfunction

    task automatic mismatch(input string sig, input logic [63:0] exp_v, input logic [63:0] act_v);
        $display("FAIL time=%0t signal=%s expected=%0h actual=%0h", $time, sig, exp_v, act_v);
        $display("Errors found");
        $fatal(1, "value mismatch");
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("Errors found");
        $fatal(1, "timeout");
    endtask

    // address counter and expected results, sampled like the decoder
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tb_count <= 0;
            for (int i = 0; i < LAT; i++) begin
                exp_valid[i] <= 1'b0;
                exp_layer[i] <= '0;
                exp_row[i]   <= '0;
                exp_value[i] <= '0;
            end
        end else begin
            exp_valid[0] <= read_update_i;
            exp_layer[0] <= backprop_pkg::layer_t'(tb_count / NV);
            exp_row[0]   <= backprop_pkg::row_t'(tb_count % NV);
            exp_value[0] <= expected_row(tb_count / NV, tb_count % NV, learning_rate_i);
            for (int i = 1; i < LAT; i++) begin
                exp_valid[i] <= exp_valid[i-1];
                exp_layer[i] <= exp_layer[i-1];
                exp_row[i]   <= exp_row[i-1];
                exp_value[i] <= exp_value[i-1];
            end
            if (!read_update_i || tb_count == backprop_pkg::ENTRIES - 1) begin
                tb_count <= 0;
            end else begin
                tb_count <= tb_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n_i && update_valid_o) begin
            beats <= beats + 1;
        end
    end

    // valid timing, count order and values against the shadow model
    assert property (@(posedge clk) disable iff (!arst_n_i)
        update_valid_o == exp_valid[LAT-1])
        else mismatch("update_valid_o", 64'($sampled(exp_valid[LAT-1])),
                      64'($sampled(update_valid_o)));

    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_valid[LAT-1] |-> update_layer_o == exp_layer[LAT-1])
        else mismatch("update_layer_o", 64'($sampled(exp_layer[LAT-1])),
                      64'($sampled(update_layer_o)));

    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_valid[LAT-1] |-> update_row_o == exp_row[LAT-1])
        else mismatch("update_row_o", 64'($sampled(exp_row[LAT-1])),
                      64'($sampled(update_row_o)));

    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_valid[LAT-1] |-> update_value_o == exp_value[LAT-1])
        else mismatch("update_value_o", 64'($sampled(exp_value[LAT-1])),
                      64'($sampled(update_value_o)));

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // one strobe, slots past the batch are dropped by the dut
    task automatic store_sample(input int l, input int r);
        store_i = 1'b1;
        layer_i = backprop_pkg::layer_t'(l);
        row_i   = backprop_pkg::row_t'(r);
        for (int j = 0; j < NV; j++) begin
            diff_cost_i[j]  = rand_elem();
            diff_act_i[j]   = rand_elem();
            diff_start_i[j] = rand_elem();
        end
        if (r < NV) begin
            for (int j = 0; j < NV; j++) begin
                model_delta[l][r][j] = q88_product(diff_cost_i[j], diff_act_i[j]);
                model_start[l][r][j] = diff_start_i[j];
            end
        end
        step();
        store_i = 1'b0;
    endtask

    task automatic update_pass(input int hold, input logic signed [15:0] lr);
        int waited;
        learning_rate_i = lr;
        step();
        read_update_i = 1'b1;
        repeat (hold) step();
        read_update_i = 1'b0;
        expected_beats = expected_beats + hold;
        // drain everything still in flight
        waited = 0;
        while (update_valid_o || exp_valid[0] || exp_valid[1] || exp_valid[2] ||
               exp_valid[LAT-1]) begin
            if (waited > 4 * LAT) begin
                timed_out("update pipeline to drain");
            end
            step();
            waited++;
        end
    endtask

    initial begin
        arst_n_i        = 1'b0;
        store_i         = 1'b0;
        layer_i         = '0;
        row_i           = '0;
        diff_cost_i     = '0;
        diff_act_i      = '0;
        diff_start_i    = '0;
        read_update_i   = 1'b0;
        learning_rate_i = '0;
        beats           = 0;
        expected_beats  = 0;
        for (int l = 0; l < NL; l++) begin
            for (int k = 0; k < NV; k++) begin
                for (int j = 0; j < NV; j++) begin
                    model_delta[l][k][j] = '0;
                    model_start[l][k][j] = '0;
                end
            end
        end

        repeat (8) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        repeat (6) step();

        // nothing written yet
        update_pass(backprop_pkg::ENTRIES, rand_elem());

        // layer 3 stays empty for now
        for (int l = 0; l < 3; l++) begin
            for (int k = 0; k < NV; k++) begin
                store_sample(l, k);
            end
        end
        store_sample(1, 3);
        update_pass(backprop_pkg::ENTRIES, 16'sh0040);

        for (int k = 0; k < NV; k++) begin
            store_sample(3, k);
        end
        // longer than one sweep to see the wrap
        update_pass(backprop_pkg::ENTRIES + 5, rand_elem());

        // zero rate
        update_pass(5, 16'sh0000);

        store_sample(2, 1);
        store_sample(0, 3);
        update_pass(2 * backprop_pkg::ENTRIES, rand_elem());
        update_pass(2, rand_elem());

        repeat (4) step();
        if (beats != expected_beats) begin
            $display("update_valid_o was high %0d cycles, %0d expected", beats, expected_beats);
            $display("Errors found");
            $fatal(1, "beat count");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* backprop_update.f */
source/backprop_pkg.sv
source/backprop_decoder.sv
source/gradient_store.sv
source/outer_product_mac.sv
source/rate_scaler.sv
source/backprop_update.sv
testbench/tb_backprop_update.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_backprop_update \
    -f backprop_update.f \
    -o Vtb_backprop_update

./obj_dir/Vtb_backprop_update 2>&1 | tee sim.log

if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
